//--- Makefile
# Verilator build for the command crossbar testbench

VERILATOR ?= verilator
TOP       ?= tb_cmd_xbar
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
JOBS      ?= 4

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

//--- hw/cmd_mux.sv
// Command multiplexer that merges the master packets onto one source with packet-locked round-robin
`timescale 1ns/1ps

module cmd_mux
    import xbar_pkt_pkg::*;
#(
    parameter int num_inputs = default_num_inputs
) (
    input  logic                  clk,
    input  logic                  reset,
    // Router side
    input  logic [num_inputs-1:0] sink_valid,
    input  xbar_beat_t            sink_beat [num_inputs],
    output logic [num_inputs-1:0] sink_ready,
    // Output stage side
    output logic                  src_valid,
    output xbar_beat_t            src_beat,
    input  logic                  src_ready
);

    logic [num_inputs-1:0] request;
    logic [num_inputs-1:0] next_grant;
    logic [num_inputs-1:0] saved_grant;
    logic [num_inputs-1:0] lock;
    logic [num_inputs-1:0] lock_held;
    logic [num_inputs-1:0] locked;
    logic                  last_cycle;
    logic                  packet_in_progress;
    logic                  update_grant;
    logic                  hold_priority;

    // ----------------------------
    // Packet lock
    // ----------------------------

    // Lock bit lives in the header, so it is kept per input for the data beats
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lock_held <= '0;
        end else begin
            for (int i = 0; i < num_inputs; i++) begin
                if (sink_valid[i] && sink_ready[i] && sink_beat[i].startofpacket) begin
                    lock_held[i] <= sink_beat[i].data.hdr.lock;
                end
            end
        end
    end

    // Lock of the packet each input is presenting right now
    always_comb begin
        for (int i = 0; i < num_inputs; i++) begin
            if (sink_valid[i] && sink_beat[i].startofpacket) begin
                lock[i] = sink_beat[i].data.hdr.lock;
            end else begin
                lock[i] = lock_held[i];
            end
        end
    end

    // Keeps a locked winner requesting even when its valid drops
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            locked <= '0;
        end else begin
            locked <= next_grant & lock;
        end
    end

    // ----------------------------
    // Grant pipeline
    // ----------------------------

    // End beat leaving on the granted input, and that packet holds no lock
    assign last_cycle = src_valid & src_ready & src_beat.endofpacket & ~(|(lock & saved_grant));

    // Busy from the first beat out until the last unlocked end beat
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            packet_in_progress <= 1'b0;
        end else if (last_cycle) begin
            packet_in_progress <= 1'b0;
        end else if (src_valid) begin
            packet_in_progress <= 1'b1;
        end
    end

    // Next grant is taken when the output goes idle or a packet ends
    // Idle start costs one cycle before the first beat goes out
    assign update_grant = (~packet_in_progress & ~src_valid) | last_cycle;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            saved_grant <= '0;
        end else if (update_grant) begin
            saved_grant <= next_grant;
        end
    end

    // ----------------------------
    // Arbiter
    // ----------------------------

    assign request = sink_valid | locked;

    // Priority is frozen while a packet streams, released on its last beat
    assign hold_priority = src_valid & ~last_cycle;

    rr_arbiter #(
        .num_inputs (num_inputs)
    ) u_arb (
        .clk                    (clk),
        .reset                  (reset),
        .request                (request),
        .grant                  (next_grant),
        .save_top_priority      (hold_priority),
        .increment_top_priority (update_grant)
    );

    // ----------------------------
    // Data path
    // ----------------------------

    assign sink_ready = {num_inputs{src_ready}} & saved_grant;
    assign src_valid  = |(saved_grant & sink_valid);

    // AND-OR select, the grant is one-hot or zero
    always_comb begin
        src_beat = '0;
        for (int i = 0; i < num_inputs; i++) begin
            src_beat = src_beat | (sink_beat[i] & {$bits(xbar_beat_t){saved_grant[i]}});
        end
    end

endmodule

//--- hw/cmd_router.sv
// Per-master router that tags every beat of a packet with the one-hot slave channel of its header
`timescale 1ns/1ps

module cmd_router
    import xbar_pkt_pkg::*;
    import xbar_map_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    // Master side
    input  logic       m_valid,
    input  xbar_beat_t m_beat,
    output logic       m_ready,
    // Toward one mux sink
    output logic       r_valid,
    output xbar_beat_t r_beat,
    input  logic       r_ready
);

    logic [chan_w-1:0] hit;
    logic [chan_w-1:0] hdr_chan;
    logic [chan_w-1:0] held_chan;

    // ----------------------------
    // Address decode
    // ----------------------------

    // Compare the header address against every region at once
    always_comb begin
        for (int i = 0; i < chan_w; i++) begin
            hit[i] = (m_beat.data.hdr.addr & slave_mask[i]) == slave_base[i];
        end
    end

    // Lowest matching region wins
    // Isolate the lowest set bit, fall back to region 0 on a miss
    assign hdr_chan = (|hit) ? (hit & (~hit + 1'b1)) : default_chan;

    // ----------------------------
    // Channel hold
    // ----------------------------

    // Later beats carry write data, so the header channel is kept here
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            held_chan <= '0;
        end else if (m_valid && r_ready && m_beat.startofpacket) begin
            held_chan <= hdr_chan;
        end
    end

    // ----------------------------
    // Beat out
    // ----------------------------

    // Handshake goes straight through, no added cycle
    assign r_valid = m_valid;
    assign m_ready = r_ready;

    always_comb begin
        r_beat = m_beat;
        // Start beat uses the live decode, data beats the held one
        r_beat.channel = m_beat.startofpacket ? hdr_chan : held_chan;
    end

endmodule

//--- hw/cmd_xbar_top.sv
// Command path top level with one router per master, the arbitrating mux and the slave output stage
`timescale 1ns/1ps

module cmd_xbar_top
    import xbar_pkt_pkg::*;
#(
    parameter int num_inputs = default_num_inputs
) (
    input  logic                  clk,
    input  logic                  reset,
    // Masters
    input  logic [num_inputs-1:0] m_valid,
    input  xbar_beat_t            m_beat [num_inputs],
    output logic [num_inputs-1:0] m_ready,
    // Shared slave port
    output logic                  s_valid,
    output xbar_beat_t            s_beat,
    input  logic                  s_ready
);

    // Router to mux links
    logic [num_inputs-1:0] r_valid;
    logic [num_inputs-1:0] r_ready;
    xbar_beat_t            r_beat [num_inputs];

    // Mux to output stage link
    logic                  src_valid;
    logic                  src_ready;
    xbar_beat_t            src_beat;

    // ----------------------------
    // Routers
    // ----------------------------

    for (genvar i = 0; i < num_inputs; i++) begin : g_router
        cmd_router u_router (
            .clk     (clk),
            .reset   (reset),
            .m_valid (m_valid[i]),
            .m_beat  (m_beat[i]),
            .m_ready (m_ready[i]),
            .r_valid (r_valid[i]),
            .r_beat  (r_beat[i]),
            .r_ready (r_ready[i])
        );
    end

    // ----------------------------
    // Mux and output stage
    // ----------------------------

    cmd_mux #(
        .num_inputs (num_inputs)
    ) u_mux (
        .clk        (clk),
        .reset      (reset),
        .sink_valid (r_valid),
        .sink_beat  (r_beat),
        .sink_ready (r_ready),
        .src_valid  (src_valid),
        .src_beat   (src_beat),
        .src_ready  (src_ready)
    );

    pkt_out_stage u_out (
        .clk      (clk),
        .reset    (reset),
        .in_valid (src_valid),
        .in_beat  (src_beat),
        .in_ready (src_ready),
        .s_valid  (s_valid),
        .s_beat   (s_beat),
        .s_ready  (s_ready)
    );

endmodule

//--- hw/pkt_out_stage.sv
// Two-entry output register toward the slave; its ready comes from a flop at full throughput
`timescale 1ns/1ps

module pkt_out_stage
    import xbar_pkt_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    // From the mux
    input  logic       in_valid,
    input  xbar_beat_t in_beat,
    output logic       in_ready,
    // To the slave
    output logic       s_valid,
    output xbar_beat_t s_beat,
    input  logic       s_ready
);

    logic       main_valid;
    logic       skid_valid;
    logic       skid_valid_n;
    logic       main_free;
    logic       in_fire;
    xbar_beat_t main_beat;
    xbar_beat_t skid_beat;

    assign in_fire   = in_valid & in_ready;
    // Main register can load when empty or draining this cycle
    assign main_free = ~main_valid | s_ready;

    // Skid fills only when a beat arrives while main is stuck
    assign skid_valid_n = main_free ? 1'b0 : (skid_valid | in_fire);

    // ----------------------------
    // Control
    // ----------------------------

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
            in_ready   <= 1'b0;
        end else begin
            skid_valid <= skid_valid_n;
            // Ready drops one cycle late, the skid takes that extra beat
            in_ready   <= ~skid_valid_n;
            if (main_free) begin
                main_valid <= skid_valid | in_fire;
            end
        end
    end

    // ----------------------------
    // Payload
    // ----------------------------

    // Skid drains first so beats keep their arrival order
    always_ff @(posedge clk) begin
        if (main_free) begin
            if (skid_valid) begin
                main_beat <= skid_beat;
            end else if (in_fire) begin
                main_beat <= in_beat;
            end
        end else if (in_fire) begin
            skid_beat <= in_beat;
        end
    end

    assign s_valid = main_valid;
    assign s_beat  = main_beat;

endmodule

//--- hw/rr_arbiter.sv
// Round-robin arbiter for the command mux; grant is combinational, top priority is a register
`timescale 1ns/1ps

module rr_arbiter
    import xbar_pkt_pkg::*;
#(
    parameter int num_inputs = default_num_inputs
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [num_inputs-1:0] request,
    output logic [num_inputs-1:0] grant,
    input  logic                  save_top_priority,
    input  logic                  increment_top_priority
);

    // One-hot, marks the input that is looked at first
    logic [num_inputs-1:0]   top_priority;
    logic [num_inputs-1:0]   past_grant;
    logic [2*num_inputs-1:0] dbl_request;
    logic [2*num_inputs-1:0] dbl_grant;

    // ----------------------------
    // Grant scan
    // ----------------------------

    // Two copies of the request so the scan can wrap past the top bit
    assign dbl_request = {request, request};

    // Subtracting the top priority clears every bit from top up to the first requester
    // The AND with the inverse leaves just that requester
    assign dbl_grant = dbl_request & ~(dbl_request - {{num_inputs{1'b0}}, top_priority});

    // Fold the two halves back, only one of them can hold the winner
    assign grant = dbl_grant[num_inputs-1:0] | dbl_grant[2*num_inputs-1:num_inputs];

    // ----------------------------
    // Top priority
    // ----------------------------

    // Position just past the winner, rotated left with wrap
    assign past_grant = (grant << 1) | (grant >> (num_inputs - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            // Input 0 goes first out of reset
            top_priority <= num_inputs'(1);
        end else if (increment_top_priority && !save_top_priority && (|grant)) begin
            top_priority <= past_grant;
        end
        // Otherwise it keeps its value, also while the owner is busy
    end

endmodule

//--- hw/xbar_map_pkg.sv
// Slave address map and one-hot channel encoding, shared by the routers and the testbench
package xbar_map_pkg;

    // ----------------------------
    // Channel encoding
    // ----------------------------

    // One channel bit per slave region
    localparam int chan_w = 5;

    // Channel for an address that hits no region (region 0)
    localparam logic [chan_w-1:0] default_chan = chan_w'(1);

    // ----------------------------
    // Region table
    // ----------------------------

    typedef logic [31:0] slave_base_t [chan_w];
    typedef logic [31:0] slave_mask_t [chan_w];

    // Region i owns addr when (addr & mask[i]) == base[i]
    // Lower index wins if two regions ever overlap
    localparam slave_base_t slave_base = '{
        32'h0000_0000,
        32'h0000_1000,
        32'h0000_2000,
        32'h0000_3000,
        32'h0000_8000
    };

    // All regions are 4 KiB blocks
    localparam slave_mask_t slave_mask = '{
        32'hffff_f000,
        32'hffff_f000,
        32'hffff_f000,
        32'hffff_f000,
        32'hffff_f000
    };

endpackage

//--- hw/xbar_pkt_pkg.sv
// Command packet beat types shared by all RTL and the testbench; compiles after the map package
package xbar_pkt_pkg;
    import xbar_map_pkg::*;

    // ----------------------------
    // Field widths
    // ----------------------------

    localparam int addr_w  = 32;
    localparam int data_w  = 64;
    localparam int be_w    = 8;
    localparam int burst_w = 4;

    // Header bits in use, the rest of the word is padding
    localparam int hdr_used_w = addr_w + be_w + 3 + burst_w;

    // Number of masters when the top level does not override it
    localparam int default_num_inputs = 2;

    // ----------------------------
    // Beat layout
    // ----------------------------

    // Header view, valid on the start beat only
    typedef struct packed {
        logic [data_w-hdr_used_w-1:0] pad;
        logic [burst_w-1:0]           burst_len;
        logic                         read;
        logic                         write;
        logic                         lock;
        logic [be_w-1:0]              byte_en;
        logic [addr_w-1:0]            addr;
    } cmd_hdr_t;

    // Same 64 bits seen as header or as write data
    typedef union packed {
        cmd_hdr_t          hdr;
        logic [data_w-1:0] wdata;
    } pkt_data_u;

    // One beat on any command link, travels with its own valid and ready
    typedef struct packed {
        pkt_data_u         data;
        logic [chan_w-1:0] channel;
        logic              startofpacket;
        logic              endofpacket;
    } xbar_beat_t;

endpackage

//--- tb.f
hw/xbar_map_pkg.sv
hw/xbar_pkt_pkg.sv
hw/rr_arbiter.sv
hw/cmd_router.sv
hw/cmd_mux.sv
hw/pkt_out_stage.sv
hw/cmd_xbar_top.sv
test/cmd_xbar_assertions.sv
test/tb_cmd_xbar.sv

//--- test/cmd_xbar_assertions.sv
// Grant and packet rules of the command mux, bound into every cmd_mux instance
`timescale 1ns/1ps

module cmd_xbar_assertions
    import xbar_pkt_pkg::*;
#(
    parameter int num_inputs = default_num_inputs
) (
    input logic                  clk,
    input logic                  reset,
    input logic [num_inputs-1:0] sink_valid,
    input xbar_beat_t            sink_beat [num_inputs],
    input logic [num_inputs-1:0] saved_grant,
    input logic                  src_valid,
    input logic                  src_ready,
    input xbar_beat_t            src_beat
);

    // At most one input owns the output
    grant_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(saved_grant))
        else $error("grant is not one-hot or zero");

    // Grant stays put after any beat that is not the end of the packet
    grant_held: assert property (@(posedge clk) disable iff (reset)
        (src_valid && src_ready && !src_beat.endofpacket) |=> $stable(saved_grant))
        else $error("grant changed inside a packet");

    // Output valid and beat come only from the granted valid sink
    for (genvar i = 0; i < num_inputs; i++) begin : g_src
        src_from_grant: assert property (@(posedge clk) disable iff (reset)
            (src_valid && saved_grant[i]) |-> (sink_valid[i] && src_beat == sink_beat[i]))
            else $error("src_valid without the beat of a granted valid sink");
    end

endmodule

bind cmd_mux cmd_xbar_assertions #(
    .num_inputs (num_inputs)
) u_assert (
    .clk         (clk),
    .reset       (reset),
    .sink_valid  (sink_valid),
    .sink_beat   (sink_beat),
    .saved_grant (saved_grant),
    .src_valid   (src_valid),
    .src_ready   (src_ready),
    .src_beat    (src_beat)
);

//--- test/cmd_xbar_trace.txt
// Columns: master _ start _ end _ 0 _ 64-bit word (header on start beats, write data otherwise)
// Header word: bits 31:0 address, 39:32 byte enable, 40 lock, 41 write. Master f ends the trace
0_1_0_0_000002ff_00001000
0_0_0_0_a0a0a0a0_00000001
0_0_1_0_a0a0a0a0_00000002
1_1_1_0_000002ff_00002040
0_1_0_0_000003ff_00003000
0_0_1_0_b0b0b0b0_00000001
0_1_1_0_000002ff_00005000
1_1_0_0_000002ff_00008010
1_0_1_0_c1c1c1c1_00000001
1_1_1_0_000003ff_00000100
1_1_0_0_000002ff_00009000
1_0_0_0_d2d2d2d2_00000001
1_0_1_0_d2d2d2d2_00000002
0_1_1_0_000002ff_00002ff8
0_1_0_0_000003ff_00000400
0_0_1_0_e3e3e3e3_00000001
0_1_1_0_000002ff_00001100
1_1_0_0_000002ff_00003abc
1_0_1_0_f4f4f4f4_00000001
f_0_0_0_00000000_00000000

//--- test/tb_cmd_xbar.sv
// Trace-driven testbench for the command crossbar slice; run from the project root
`timescale 1ns/1ps

module tb_cmd_xbar
    import xbar_pkt_pkg::*;
    import xbar_map_pkg::*;
();

    logic       clk;
    logic       reset;
    logic [1:0] m_valid;
    xbar_beat_t m_beat [2];
    logic [1:0] m_ready;
    logic       s_valid;
    xbar_beat_t s_beat;
    logic       s_ready;

    logic [79:0] trace_mem [0:63];
    xbar_beat_t  stim_q [2][$];
    xbar_beat_t  exp_q [2][$];
    logic        alt_q [2][$];
    logic [1:0]  m_fire;
    logic [31:0] lfsr;
    int          total_beats;
    int          received;
    int          cycles;
    int          limit;
    int          ready_left;
    // Beats taken by the output stage and not yet at the slave
    int          in_stage;

    // Output side packet tracking
    logic in_packet;
    int   owner;
    logic cur_lock;
    logic cur_alt;
    logic have_prev;
    int   prev_owner;
    logic prev_lock;
    logic prev_alt;

    cmd_xbar_top #(
        .num_inputs (2)
    ) uut (
        .clk     (clk),
        .reset   (reset),
        .m_valid (m_valid),
        .m_beat  (m_beat),
        .m_ready (m_ready),
        .s_valid (s_valid),
        .s_beat  (s_beat),
        .s_ready (s_ready)
    );

    always #4 clk = ~clk;

    // ------------------------------
    // Helpers
    // ------------------------------

    // Galois LFSR, one step per bit taken
    function automatic logic rand_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hd000_0001) : (lfsr >> 1);
        return b;
    endfunction

    // Map rule: lowest matching region, region 0 on a miss
    function automatic logic [chan_w-1:0] region_chan(input logic [31:0] addr);
        logic [chan_w-1:0] c;
        c = '0;
        for (int i = chan_w - 1; i >= 0; i--) begin
            if ((addr & slave_mask[i]) == slave_base[i]) begin
                c = chan_w'(1) << i;
            end
        end
        if (c == '0) begin
            c = chan_w'(1);
        end
        return c;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_beat(input string name, input xbar_beat_t exp, input xbar_beat_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
            abort_run("beat mismatch");
        end
    endtask

    task automatic check_chan(input string name, input logic [chan_w-1:0] exp,
                              input logic [chan_w-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
            abort_run("channel mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
            abort_run("handshake mismatch");
        end
    endtask

    // ------------------------------
    // Output checking
    // ------------------------------

    task automatic check_output(input xbar_beat_t b);
        xbar_beat_t exp;
        if (b.startofpacket) begin
            if (in_packet) begin
                abort_run("start beat arrived inside another packet");
            end
            // Owner is the master whose queue head carries this header
            if (exp_q[0].size() > 0 && exp_q[0][0].data.wdata === b.data.wdata) begin
                owner = 0;
            end else if (exp_q[1].size() > 0 && exp_q[1][0].data.wdata === b.data.wdata) begin
                owner = 1;
            end else begin
                abort_run("start beat matches neither master's next packet");
            end
            if (have_prev && prev_lock && exp_q[prev_owner].size() > 0) begin
                if (owner != prev_owner) begin
                    abort_run("locked master lost the grant to the other master");
                end
            end else if (have_prev && !prev_lock && prev_alt && owner == prev_owner) begin
                abort_run("round-robin did not alternate between waiting masters");
            end
            if (alt_q[owner].size() == 0) begin
                abort_run("packet at slave was never accepted from its master");
            end
            cur_alt   = alt_q[owner].pop_front();
            cur_lock  = b.data.hdr.lock;
            in_packet = 1'b1;
        end else if (!in_packet) begin
            abort_run("data beat arrived outside a packet");
        end
        if (exp_q[owner].size() == 0) begin
            abort_run("extra beat from a master with nothing left to send");
        end
        exp = exp_q[owner].pop_front();
        check_chan("s_beat.channel", exp.channel, b.channel);
        check_beat("s_beat", exp, b);
        if (b.endofpacket) begin
            in_packet  = 1'b0;
            have_prev  = 1'b1;
            prev_owner = owner;
            prev_lock  = cur_lock;
            prev_alt   = cur_alt;
        end
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------

    task automatic drive_inputs();
        for (int m = 0; m < 2; m++) begin
            if (m_fire[m]) begin
                void'(stim_q[m].pop_front());
                m_valid[m] = 1'b0;
                m_fire[m]  = 1'b0;
            end
            // Valid held until accepted, gaps only between beats
            if (!m_valid[m] && stim_q[m].size() > 0) begin
                if (rand_bit() | rand_bit()) begin
                    m_valid[m] = 1'b1;
                    m_beat[m]  = stim_q[m][0];
                end
            end
        end
        if (ready_left == 0) begin
            s_ready    = rand_bit();
            ready_left = 1 + {rand_bit(), rand_bit(), rand_bit(), rand_bit()};
        end
        ready_left--;
    endtask

    task automatic sample_handshakes();
        // Output stage shows valid while it holds a beat, and stops both masters when full
        check_flag("s_valid", in_stage > 0, s_valid);
        if (in_stage == 2) begin
            check_flag("m_ready[0]", 1'b0, m_ready[0]);
            check_flag("m_ready[1]", 1'b0, m_ready[1]);
        end
        for (int m = 0; m < 2; m++) begin
            m_fire[m] = m_valid[m] & m_ready[m];
            // Other master waiting with a start beat means the next grant must switch
            if (m_fire[m] && m_beat[m].startofpacket) begin
                alt_q[m].push_back(m_valid[1-m] && stim_q[1-m].size() > 0 &&
                                   stim_q[1-m][0].startofpacket);
            end
        end
        if (s_valid && s_ready) begin
            check_output(s_beat);
            received++;
            in_stage--;
        end
        in_stage += m_fire[0] + m_fire[1];
    endtask

    initial begin
        xbar_beat_t b;
        int idx;
        clk        = 1'b0;
        reset      = 1'b1;
        m_valid    = '0;
        m_beat[0]  = '0;
        m_beat[1]  = '0;
        s_ready    = 1'b0;
        m_fire     = '0;
        lfsr       = 32'h2ab7;
        ready_left = 0;
        in_stage   = 0;
        in_packet  = 1'b0;
        have_prev  = 1'b0;
        owner      = 0;
        received   = 0;
        cycles     = 0;
        total_beats = 0;
        $readmemh("test/cmd_xbar_trace.txt", trace_mem);
        idx = 0;
        while (trace_mem[idx][79:76] != 4'hf) begin
            if (trace_mem[idx][79:76] > 4'h1) begin
                abort_run("trace line has an unknown master");
            end
            b = '0;
            b.data.wdata   = trace_mem[idx][63:0];
            b.startofpacket = trace_mem[idx][72];
            b.endofpacket   = trace_mem[idx][68];
            stim_q[trace_mem[idx][76]].push_back(b);
            if (b.startofpacket) begin
                b.channel = region_chan(b.data.hdr.addr);
            end else begin
                b.channel = exp_q[trace_mem[idx][76]][$].channel;
            end
            exp_q[trace_mem[idx][76]].push_back(b);
            total_beats++;
            idx++;
        end
        limit = 40 * total_beats + 100;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while (received < total_beats) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                abort_run("timeout: beats still missing");
            end
            drive_inputs();
            #2;
            sample_handshakes();
        end
        $display("test passed");
        $finish;
    end

endmodule
